//--- src/btb_pkg.sv
package btb_pkg;

	localparam int pc_bits     = 32;                  // Fetch and execute address width
	localparam int btb_entries = 16;                  // Fully associative, no sets
	localparam int idx_bits    = $clog2(btb_entries); // Entry index width
	localparam int tag_bits    = 10;                  // PC[11:2]
	localparam int target_bits = 12;                  // Target[13:2]
	localparam int tag_lsb     = 2;                   // Word aligned, low bits dropped

	// Update decoded from one resolved branch
	typedef enum logic [1:0] {
		upd_none    = 2'd0, // Nothing to do
		upd_insert  = 2'd1, // Taken, not present
		upd_refresh = 2'd2, // Taken, present with stale target
		upd_evict   = 2'd3  // Not taken, present
	} upd_op_e;

	typedef logic [idx_bits-1:0] entry_idx_t;

	// Lookup tag of a PC
	function automatic logic [tag_bits-1:0] pc_tag(input logic [pc_bits-1:0] pc);
		return pc[tag_lsb +: tag_bits];
	endfunction

	// Low target bits kept in the table
	function automatic logic [target_bits-1:0] pc_target(input logic [pc_bits-1:0] pc);
		return pc[tag_lsb +: target_bits];
	endfunction

	// Predicted target: fetch PC upper bits, stored bits, word alignment
	function automatic logic [pc_bits-1:0] build_target_pc(
		input logic [pc_bits-1:0]     pc,
		input logic [target_bits-1:0] stored
	);
		return {pc[pc_bits-1:tag_lsb+target_bits], stored, {tag_lsb{1'b0}}};
	endfunction

endpackage

//--- src/btb_tag_cam.sv
module btb_tag_cam (
	input  logic [btb_pkg::pc_bits-1:0]                           current_pc, // Fetch lookup
	input  logic [btb_pkg::pc_bits-1:0]                           ex_pc,      // Resolved branch
	input  logic [btb_pkg::btb_entries-1:0][btb_pkg::tag_bits-1:0] tags,      // Stored tags
	input  logic [btb_pkg::btb_entries-1:0]                       valid,      // Entry valid bits
	output logic [btb_pkg::btb_entries-1:0]                       fetch_hit,  // One-hot or zero
	output logic [btb_pkg::btb_entries-1:0]                       ex_hit      // One-hot or zero
);

	logic [btb_pkg::tag_bits-1:0] fetch_tag; // Tag of the fetch PC
	logic [btb_pkg::tag_bits-1:0] ex_tag;    // Tag of the execute PC

	assign fetch_tag = btb_pkg::pc_tag(current_pc);
	assign ex_tag    = btb_pkg::pc_tag(ex_pc);

	// Both ports search all entries at once
	always_comb begin
		fetch_hit = '0;
		ex_hit    = '0;
		for (int i = 0; i < btb_pkg::btb_entries; i++) begin
			fetch_hit[i] = valid[i] && (tags[i] == fetch_tag); // Invalid slots never match
			ex_hit[i]    = valid[i] && (tags[i] == ex_tag);
		end
	end

	// Tags are unique in the table since an insert only follows a miss,
	// so neither vector carries more than one set bit

endmodule

//--- src/btb_target_store.sv
module btb_target_store (
	input  logic                                                   clock,
	input  logic                                                   reset,
	input  logic                                                   enable,       // Freezes all updates
	input  logic                                                   wr_en,        // Write tag and target
	input  logic                                                   evict_en,     // Clear one valid bit
	input  btb_pkg::entry_idx_t                                    wr_idx,       // Entry to write or clear
	input  logic [btb_pkg::tag_bits-1:0]                           wr_tag,
	input  logic [btb_pkg::target_bits-1:0]                        wr_target,
	input  logic [btb_pkg::btb_entries-1:0]                        fetch_hit,    // From CAM, fetch port
	input  logic [btb_pkg::btb_entries-1:0]                        ex_hit,       // From CAM, execute port
	input  logic [btb_pkg::pc_bits-1:0]                            current_pc,
	output logic [btb_pkg::btb_entries-1:0][btb_pkg::tag_bits-1:0] tags,
	output logic [btb_pkg::btb_entries-1:0]                        valid,
	output logic [btb_pkg::pc_bits-1:0]                            target_pc,    // Predicted target
	output logic                                                   valid_target, // Prediction usable
	output logic [btb_pkg::target_bits-1:0]                        ex_stored_target
);

	logic [btb_pkg::btb_entries-1:0][btb_pkg::target_bits-1:0] targets; // Stored target bits
	logic [btb_pkg::target_bits-1:0]                           fetch_target; // Hit entry, fetch

	// Valid bits are the only control state here
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0; // Empty table after reset
		end else if (enable) begin
			if (wr_en) begin
				valid[wr_idx] <= 1'b1; // Insert or refresh
			end else if (evict_en) begin
				valid[wr_idx] <= 1'b0; // Not-taken hit drops out
			end
		end
	end

	// Payload arrays
	always_ff @(posedge clock) begin
		if (enable && wr_en) begin
			tags[wr_idx]    <= wr_tag;
			targets[wr_idx] <= wr_target;
		end
	end

	// Hit vectors are one-hot, so an OR of the selected rows is the mux
	always_comb begin
		fetch_target     = '0;
		ex_stored_target = '0;
		for (int i = 0; i < btb_pkg::btb_entries; i++) begin
			if (fetch_hit[i]) begin
				fetch_target = fetch_target | targets[i];
			end
			if (ex_hit[i]) begin
				ex_stored_target = ex_stored_target | targets[i]; // For refresh compare
			end
		end
	end

	assign target_pc    = btb_pkg::build_target_pc(current_pc, fetch_target);
	assign valid_target = enable && (|fetch_hit); // No prediction while frozen

endmodule

//--- src/btb_victim_select.sv
module btb_victim_select (
	input  logic                            clock,
	input  logic                            reset,
	input  logic [btb_pkg::btb_entries-1:0] valid,     // Entry valid bits
	input  logic                            advance,   // Insert into a full table
	output btb_pkg::entry_idx_t             victim_idx // Slot for the next insert
);

	btb_pkg::entry_idx_t rr_ptr;   // Round-robin pointer, used only when full
	btb_pkg::entry_idx_t free_idx; // Lowest invalid entry
	logic                any_free; // At least one slot empty

	// Scan from the top down so the lowest free slot wins
	always_comb begin
		free_idx = '0;
		any_free = 1'b0;
		for (int i = btb_pkg::btb_entries - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_idx = btb_pkg::entry_idx_t'(i);
				any_free = 1'b1;
			end
		end
	end

	// Refill holes left by eviction before the pointer is used
	assign victim_idx = any_free ? free_idx : rr_ptr;

	always_ff @(posedge clock) begin
		if (reset) begin
			rr_ptr <= '0;
		end else if (advance) begin
			rr_ptr <= rr_ptr + 1'b1; // Wraps at the table size
		end
	end

	// With a full table the oldest insert is replaced first, since the
	// pointer trails the fill order that the free search produced

endmodule

//--- src/btb_update_ctrl.sv
module btb_update_ctrl (
	input  logic                               enable,           // Updates frozen when low
	input  logic                               ex_en_branch,     // Branch resolved this cycle
	input  logic                               ex_branch_taken,
	input  logic [btb_pkg::pc_bits-1:0]        ex_pc,
	input  logic [btb_pkg::pc_bits-1:0]        calculated_pc,    // Resolved target
	input  logic [btb_pkg::btb_entries-1:0]    ex_hit,           // CAM result for ex_pc
	input  logic [btb_pkg::target_bits-1:0]    ex_stored_target, // Target in the hit entry
	input  btb_pkg::entry_idx_t                victim_idx,
	input  logic [btb_pkg::btb_entries-1:0]    valid,
	output btb_pkg::upd_op_e                   upd_op,
	output logic                               wr_en,
	output logic                               evict_en,
	output btb_pkg::entry_idx_t                wr_idx,
	output logic [btb_pkg::tag_bits-1:0]       wr_tag,
	output logic [btb_pkg::target_bits-1:0]    wr_target,
	output logic                               advance           // Step round-robin pointer
);

	logic                hit;     // ex_pc already stored
	btb_pkg::entry_idx_t hit_idx; // Encoded ex_hit position

	assign hit       = |ex_hit;
	assign wr_tag    = btb_pkg::pc_tag(ex_pc);
	assign wr_target = btb_pkg::pc_target(calculated_pc);

	// One-hot to binary
	always_comb begin
		hit_idx = '0;
		for (int i = 0; i < btb_pkg::btb_entries; i++) begin
			if (ex_hit[i]) begin
				hit_idx = hit_idx | btb_pkg::entry_idx_t'(i);
			end
		end
	end

	// Resolution decode
	always_comb begin
		upd_op = btb_pkg::upd_none;
		if (enable && ex_en_branch) begin
			if (ex_branch_taken && !hit) begin
				upd_op = btb_pkg::upd_insert;
			end else if (ex_branch_taken && (ex_stored_target != wr_target)) begin
				upd_op = btb_pkg::upd_refresh; // Same branch, new target
			end else if (!ex_branch_taken && hit) begin
				upd_op = btb_pkg::upd_evict;
			end
		end
	end

	assign wr_en    = (upd_op == btb_pkg::upd_insert) || (upd_op == btb_pkg::upd_refresh);
	assign evict_en = (upd_op == btb_pkg::upd_evict);
	assign wr_idx   = (upd_op == btb_pkg::upd_insert) ? victim_idx : hit_idx;
	assign advance  = (upd_op == btb_pkg::upd_insert) && (&valid); // Replacing a live entry

endmodule

//--- src/btb_top.sv
module btb_top (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        enable,          // Clock enable for the whole buffer
	input  logic [btb_pkg::pc_bits-1:0] current_pc,      // Fetch PC
	input  logic [btb_pkg::pc_bits-1:0] ex_pc,           // PC of the resolved branch
	input  logic [btb_pkg::pc_bits-1:0] calculated_pc,   // Resolved target
	input  logic                        ex_en_branch,    // Resolution strobe
	input  logic                        ex_branch_taken,
	output logic [btb_pkg::pc_bits-1:0] target_pc,       // Predicted target, same cycle
	output logic                        valid_target
);

	logic [btb_pkg::btb_entries-1:0][btb_pkg::tag_bits-1:0] tags;
	logic [btb_pkg::btb_entries-1:0]                        valid;
	logic [btb_pkg::btb_entries-1:0]                        fetch_hit;
	logic [btb_pkg::btb_entries-1:0]                        ex_hit;
	logic [btb_pkg::target_bits-1:0]                        ex_stored_target;
	logic                                                   wr_en;
	logic                                                   evict_en;
	btb_pkg::entry_idx_t                                    wr_idx;
	logic [btb_pkg::tag_bits-1:0]                           wr_tag;
	logic [btb_pkg::target_bits-1:0]                        wr_target;
	btb_pkg::entry_idx_t                                    victim_idx;
	logic                                                   advance;

	btb_tag_cam cam_i (
		.current_pc (current_pc),
		.ex_pc      (ex_pc),
		.tags       (tags),
		.valid      (valid),
		.fetch_hit  (fetch_hit),
		.ex_hit     (ex_hit)
	);

	btb_target_store store_i (
		.clock            (clock),
		.reset            (reset),
		.enable           (enable),
		.wr_en            (wr_en),
		.evict_en         (evict_en),
		.wr_idx           (wr_idx),
		.wr_tag           (wr_tag),
		.wr_target        (wr_target),
		.fetch_hit        (fetch_hit),
		.ex_hit           (ex_hit),
		.current_pc       (current_pc),
		.tags             (tags),
		.valid            (valid),
		.target_pc        (target_pc),
		.valid_target     (valid_target),
		.ex_stored_target (ex_stored_target)
	);

	btb_victim_select victim_i (
		.clock      (clock),
		.reset      (reset),
		.valid      (valid),
		.advance    (advance),
		.victim_idx (victim_idx)
	);

	btb_update_ctrl ctrl_i (
		.enable           (enable),
		.ex_en_branch     (ex_en_branch),
		.ex_branch_taken  (ex_branch_taken),
		.ex_pc            (ex_pc),
		.calculated_pc    (calculated_pc),
		.ex_hit           (ex_hit),
		.ex_stored_target (ex_stored_target),
		.victim_idx       (victim_idx),
		.valid            (valid),
		.upd_op           (),
		.wr_en            (wr_en),
		.evict_en         (evict_en),
		.wr_idx           (wr_idx),
		.wr_tag           (wr_tag),
		.wr_target        (wr_target),
		.advance          (advance)
	);

endmodule

//--- tb/btb_clock_gen.sv
module btb_clock_gen (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam time half_period = 50; // 100 ns clock period

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// Synchronous reset held over the first two rising edges
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- tb/btb_tb.sv
module btb_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clock_period = 100; // ns, matches btb_clock_gen
	localparam int settle_delay = 10;  // Check point after the falling edge
	localparam int margin_rows  = 10;  // Extra cycles before the watchdog fires

	// One table row: stimulus, then expected fetch result before the row's update
	typedef struct packed {
		logic                        en;
		logic [btb_pkg::pc_bits-1:0] cur;
		logic [btb_pkg::pc_bits-1:0] xpc;
		logic [btb_pkg::pc_bits-1:0] calc;
		logic                        br;
		logic                        tk;
		logic                        exp_valid;
		logic [btb_pkg::pc_bits-1:0] exp_target;
	} row_t;

	logic                        clock;
	logic                        reset;
	logic                        enable;
	logic [btb_pkg::pc_bits-1:0] current_pc;
	logic [btb_pkg::pc_bits-1:0] ex_pc;
	logic [btb_pkg::pc_bits-1:0] calculated_pc;
	logic                        ex_en_branch;
	logic                        ex_branch_taken;
	logic [btb_pkg::pc_bits-1:0] target_pc;
	logic                        valid_target;

	row_t rows[$];          // Stimulus table
	logic table_ready = 0;  // Starts the watchdog
	int   fail_count  = 0;  // Failed checks
	int   check_count = 0;
	int   rows_failed = 0;

	btb_clock_gen clock_gen_i (
		.clock (clock),
		.reset (reset)
	);

	btb_top dut_i (
		.clock           (clock),
		.reset           (reset),
		.enable          (enable),
		.current_pc      (current_pc),
		.ex_pc           (ex_pc),
		.calculated_pc   (calculated_pc),
		.ex_en_branch    (ex_en_branch),
		.ex_branch_taken (ex_branch_taken),
		.target_pc       (target_pc),
		.valid_target    (valid_target)
	);

	// Upper fetch bits, target bits 13 to 2, two zero bits
	function automatic logic [31:0] rebuild_target(input logic [31:0] fetch, input logic [31:0] tgt);
		return {fetch[31:14], tgt[13:2], 2'b00};
	endfunction

	// Branch i sits at tag i
	function automatic logic [31:0] branch_pc(input int i);
		return 32'h0000_1000 + i * 4;
	endfunction

	function automatic logic [31:0] branch_target(input int i);
		return 32'h3000_0200 + i * 16; // Distinct bits 13 to 2 per branch
	endfunction

	function automatic logic [31:0] predicted_for(input int i);
		return rebuild_target(branch_pc(i), branch_target(i));
	endfunction

	task automatic add_row(input logic en, input logic [31:0] cur, input logic [31:0] xpc,
			input logic [31:0] calc, input logic br, input logic tk,
			input logic exp_v, input logic [31:0] exp_t);
		row_t r;
		r = '{en, cur, xpc, calc, br, tk, exp_v, exp_t};
		rows.push_back(r);
	endtask

	// Fetch only, no resolution
	task automatic add_fetch(input logic en, input logic [31:0] cur, input logic exp_v,
			input logic [31:0] exp_t);
		add_row(en, cur, 32'h0, 32'h0, 1'b0, 1'b0, exp_v, exp_t);
	endtask

	task automatic build_table();
		logic [31:0] pa;
		pa = 32'h2000_0100;
		// Empty after reset
		add_fetch(1'b1, 32'h0000_1234, 1'b0, 32'h0);
		add_fetch(1'b1, 32'h8000_0040, 1'b0, 32'h0);
		// Insert, then predict with rebuilt upper bits
		add_row(1'b1, pa, pa, 32'h2000_5678, 1'b1, 1'b1, 1'b0, 32'h0);
		add_fetch(1'b1, pa, 1'b1, rebuild_target(pa, 32'h2000_5678));
		add_fetch(1'b1, 32'h7777_c100, 1'b1, rebuild_target(32'h7777_c100, 32'h2000_5678));
		// Refresh, same-cycle fetch still sees the old target
		add_row(1'b1, pa, pa, 32'h2000_9abc, 1'b1, 1'b1, 1'b1,
			rebuild_target(pa, 32'h2000_5678));
		add_fetch(1'b1, pa, 1'b1, rebuild_target(pa, 32'h2000_9abc));
		// Not-taken hit evicts
		add_row(1'b1, pa, pa, 32'h0, 1'b1, 1'b0, 1'b1, rebuild_target(pa, 32'h2000_9abc));
		add_fetch(1'b1, pa, 1'b0, 32'h0);
		// Fill all sixteen entries, each row fetches the previous insert
		add_row(1'b1, branch_pc(0), branch_pc(0), branch_target(0), 1'b1, 1'b1, 1'b0, 32'h0);
		for (int i = 1; i < 16; i++) begin
			add_row(1'b1, branch_pc(i - 1), branch_pc(i), branch_target(i), 1'b1, 1'b1,
				1'b1, predicted_for(i - 1));
		end
		// Seventeenth replaces the first insert, eighteenth the second
		add_row(1'b1, branch_pc(15), branch_pc(16), branch_target(16), 1'b1, 1'b1,
			1'b1, predicted_for(15));
		add_row(1'b1, branch_pc(0), branch_pc(17), branch_target(17), 1'b1, 1'b1, 1'b0, 32'h0);
		add_fetch(1'b1, branch_pc(1), 1'b0, 32'h0);
		add_fetch(1'b1, branch_pc(16), 1'b1, predicted_for(16));
		add_fetch(1'b1, branch_pc(17), 1'b1, predicted_for(17));
		// Evicted slot is refilled before the pointer moves on
		add_row(1'b1, branch_pc(2), branch_pc(5), 32'h0, 1'b1, 1'b0, 1'b1, predicted_for(2));
		add_row(1'b1, branch_pc(5), branch_pc(18), branch_target(18), 1'b1, 1'b1, 1'b0, 32'h0);
		add_row(1'b1, branch_pc(2), branch_pc(19), branch_target(19), 1'b1, 1'b1,
			1'b1, predicted_for(2)); // Pointer still on entry 2
		add_fetch(1'b1, branch_pc(2), 1'b0, 32'h0);
		add_fetch(1'b1, branch_pc(18), 1'b1, predicted_for(18));
		add_fetch(1'b1, branch_pc(19), 1'b1, predicted_for(19));
		add_fetch(1'b1, branch_pc(3), 1'b1, predicted_for(3));
		// Frozen: no prediction, resolutions ignored
		add_fetch(1'b0, branch_pc(3), 1'b0, 32'h0);
		add_row(1'b0, branch_pc(3), branch_pc(3), 32'h0, 1'b1, 1'b0, 1'b0, 32'h0);
		add_row(1'b0, branch_pc(3), branch_pc(20), branch_target(20), 1'b1, 1'b1, 1'b0, 32'h0);
		add_row(1'b0, branch_pc(4), branch_pc(4), 32'h3000_0ff0, 1'b1, 1'b1, 1'b0, 32'h0);
		add_fetch(1'b1, branch_pc(3), 1'b1, predicted_for(3));
		add_fetch(1'b1, branch_pc(20), 1'b0, 32'h0);
		add_fetch(1'b1, branch_pc(4), 1'b1, predicted_for(4));
	endtask

	task automatic check_valid(input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			$display("Fail valid_target: got %h, expected %h", actual, expected);
			fail_count++;
		end
	endtask

	task automatic check_target(input logic [btb_pkg::pc_bits-1:0] actual,
			input logic [btb_pkg::pc_bits-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			$display("Fail target_pc: got %h, expected %h", actual, expected);
			fail_count++;
		end
	endtask

	// Main sequence
	initial begin
		row_t r;
		int   fails_before;
		enable          = 1'b0;
		current_pc      = '0;
		ex_pc           = '0;
		calculated_pc   = '0;
		ex_en_branch    = 1'b0;
		ex_branch_taken = 1'b0;
		build_table();
		table_ready = 1'b1;
		wait (reset === 1'b0);
		for (int n = 0; n < rows.size(); n++) begin
			@(negedge clock);
			r               = rows[n];
			enable          = r.en;
			current_pc      = r.cur;
			ex_pc           = r.xpc;
			calculated_pc   = r.calc;
			ex_en_branch    = r.br;
			ex_branch_taken = r.tk;
			#settle_delay;                // Fetch path settled, update not yet taken
			fails_before = fail_count;
			check_valid(valid_target, r.exp_valid);
			if (r.exp_valid) begin
				check_target(target_pc, r.exp_target);
			end
			if (fail_count == fails_before) begin
				$display("Row %0d: ok", n);
			end else begin
				$display("Row %0d: mismatch", n);
				rows_failed++;
			end
		end
		@(negedge clock);
		ex_en_branch = 1'b0;
		$display("%0d rows run, %0d rows with errors, %0d of %0d checks failed",
			rows.size(), rows_failed, fail_count, check_count);
		if (fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		wait (table_ready);
		#((rows.size() + margin_rows) * clock_period);
		$display("Timeout: the table did not finish in the expected number of cycles");
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- all.f
src/btb_pkg.sv
src/btb_tag_cam.sv
src/btb_target_store.sv
src/btb_victim_select.sv
src/btb_update_ctrl.sv
src/btb_top.sv
tb/btb_clock_gen.sv
tb/btb_tb.sv

//--- Bender.yml
package:
  name: btb

dependencies: {}

sources:
  # Design, in compile order
  - src/btb_pkg.sv
  - src/btb_tag_cam.sv
  - src/btb_target_store.sv
  - src/btb_victim_select.sv
  - src/btb_update_ctrl.sv
  - src/btb_top.sv

  # Testbench
  - target: test
    files:
      - tb/btb_clock_gen.sv
      - tb/btb_tb.sv
